// ==== hw/uart_dbg_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Build-time constants of the UART debug server: bit timing, memory
// size and the protocol bytes exchanged with the host. Included by
// the package and by every module that needs one of these values.
//////////////////////////////////////////////////////////////////////

`ifndef UART_DBG_DEFINES_SVH
`define UART_DBG_DEFINES_SVH

// Clock cycles per bit period, kept a power of two
`define UART_DBG_CLKS_PER_BIT 8

// Byte memory size
`define UART_DBG_MEM_DEPTH 256

// Protocol bytes
`define UART_DBG_CMD_READ  8'h11
`define UART_DBG_CMD_WRITE 8'h12
`define UART_DBG_ACK       8'h06
`define UART_DBG_EOT       8'h04

`endif

// ==== hw/uart_dbg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types of the UART debug server. Modules use scoped names in
// their port lists and a wildcard import inside the body.
//////////////////////////////////////////////////////////////////////

`include "uart_dbg_defines.svh"

package uart_dbg_pkg;

  // One byte on the line or in memory
  typedef logic [7:0] byte_t;

  // Memory index, wraps at the memory depth
  typedef logic [$clog2(`UART_DBG_MEM_DEPTH)-1:0] mem_addr_t;

  // Data byte count of one exchange
  typedef logic [15:0] xfer_len_t;

  // Position inside an 8-byte address or length field
  typedef logic [2:0] field_idx_t;

  // Command engine FSM
  typedef enum logic [2:0] {
    IDLE, ADDR, LEN, SEND_ACK, WR_DATA, RD_FETCH, RD_SEND, SEND_EOT
  } engine_state_e;

endpackage

// ==== hw/uart_dbg_rx.sv ====
//////////////////////////////////////////////////////////////////////
// 8N1 UART receiver. Samples each bit in the middle of its period and
// pulses rx_valid_o for one cycle when a frame with a good stop bit
// has arrived. The byte is held on rx_byte_o until the next frame.
//////////////////////////////////////////////////////////////////////

`include "uart_dbg_defines.svh"

module uart_dbg_rx (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_byte_o
);

  import uart_dbg_pkg::*;

  localparam int unsigned clks_per_bit = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned cnt_w        = $clog2(clks_per_bit);

  logic [1:0]       sync_q;
  logic             rx_prev_q;
  logic             busy_q;
  logic [cnt_w-1:0] cyc_cnt_q;
  // 0 is the start bit, 1 to 8 data, 9 stop
  logic [3:0]       bit_idx_q;
  byte_t            shift_q;
  logic             rx_sync;
  logic             sample;

  assign rx_sync = sync_q[1];
  assign sample  = busy_q && (cyc_cnt_q == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
      busy_q    <= 1'b0;
      cyc_cnt_q <= '0;
      bit_idx_q <= '0;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_sync;
      if (!busy_q) begin
        // Falling edge starts a frame, first sample half a bit later
        if (rx_prev_q && !rx_sync) begin
          busy_q    <= 1'b1;
          cyc_cnt_q <= cnt_w'(clks_per_bit / 2 - 1);
          bit_idx_q <= '0;
        end
      end else if (sample) begin
        cyc_cnt_q <= cnt_w'(clks_per_bit - 1);
        bit_idx_q <= bit_idx_q + 4'd1;
        // False start or end of frame
        if ((bit_idx_q == 4'd0 && rx_sync) || bit_idx_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end else begin
        cyc_cnt_q <= cyc_cnt_q - cnt_w'(1);
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  assign rx_valid_o = sample && (bit_idx_q == 4'd9) && rx_sync;
  assign rx_byte_o  = shift_q;

endmodule

// ==== hw/uart_dbg_tx.sv ====
//////////////////////////////////////////////////////////////////////
// 8N1 UART transmitter. Takes one byte per valid/ready handshake and
// starts the frame in the next cycle. Ready is only high while the
// line is idle, so a frame is never interrupted.
//////////////////////////////////////////////////////////////////////

`include "uart_dbg_defines.svh"

module uart_dbg_tx (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                tx_valid_i,
  input  uart_dbg_pkg::byte_t tx_byte_i,
  output logic                tx_ready_o,
  output logic                tx_o
);

  localparam int unsigned clks_per_bit = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned cnt_w        = $clog2(clks_per_bit);

  logic             busy_q;
  logic [cnt_w-1:0] cyc_cnt_q;
  logic [3:0]       bit_idx_q;
  // Stop, data and start bit, shifted out from bit 0
  logic [9:0]       frame_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      cyc_cnt_q <= '0;
      bit_idx_q <= '0;
      frame_q   <= '1;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        busy_q    <= 1'b1;
        cyc_cnt_q <= cnt_w'(clks_per_bit - 1);
        bit_idx_q <= '0;
        frame_q   <= {1'b1, tx_byte_i, 1'b0};
      end
    end else if (cyc_cnt_q == '0) begin
      // Next bit, shifting in idle level behind the frame
      cyc_cnt_q <= cnt_w'(clks_per_bit - 1);
      bit_idx_q <= bit_idx_q + 4'd1;
      frame_q   <= {1'b1, frame_q[9:1]};
      if (bit_idx_q == 4'd9) begin
        busy_q <= 1'b0;
      end
    end else begin
      cyc_cnt_q <= cyc_cnt_q - cnt_w'(1);
    end
  end

  assign tx_ready_o = !busy_q;
  assign tx_o       = frame_q[0];

endmodule

// ==== hw/uart_dbg_engine.sv ====
//////////////////////////////////////////////////////////////////////
// Command engine of the UART debug server. Parses ACK challenges and
// read/write commands from the receiver, owns the byte memory and
// sequences the reply bytes towards the transmitter.
//////////////////////////////////////////////////////////////////////

`include "uart_dbg_defines.svh"

module uart_dbg_engine (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                rx_valid_i,
  input  uart_dbg_pkg::byte_t rx_byte_i,
  output logic                tx_valid_o,
  output uart_dbg_pkg::byte_t tx_byte_o,
  input  logic                tx_ready_i
);

  import uart_dbg_pkg::*;

  engine_state_e state_q;
  field_idx_t    idx_q;
  mem_addr_t     addr_q;
  xfer_len_t     len_q;
  // Set for read/write, clear for a bare ACK challenge
  logic          cmd_q;
  logic          is_read_q;
  byte_t         rd_data_q;
  byte_t         mem_q [`UART_DBG_MEM_DEPTH];
  logic          tx_fire;
  logic          last_byte;

  assign tx_fire   = tx_valid_o && tx_ready_i;
  assign last_byte = (len_q == xfer_len_t'(1));

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      idx_q     <= '0;
      addr_q    <= '0;
      len_q     <= '0;
      cmd_q     <= 1'b0;
      is_read_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (rx_valid_i) begin
            idx_q <= '0;
            if (rx_byte_i == `UART_DBG_CMD_READ || rx_byte_i == `UART_DBG_CMD_WRITE) begin
              state_q   <= ADDR;
              cmd_q     <= 1'b1;
              is_read_q <= (rx_byte_i == `UART_DBG_CMD_READ);
            end else if (rx_byte_i == `UART_DBG_ACK) begin
              state_q <= SEND_ACK;
              cmd_q   <= 1'b0;
            end
          end
        end
        ADDR: begin
          if (rx_valid_i) begin
            // Only the lowest byte reaches the memory index
            if (idx_q == field_idx_t'(0)) begin
              addr_q <= mem_addr_t'(rx_byte_i);
            end
            idx_q <= idx_q + field_idx_t'(1);
            if (idx_q == field_idx_t'(7)) begin
              state_q <= LEN;
            end
          end
        end
        LEN: begin
          if (rx_valid_i) begin
            if (idx_q == field_idx_t'(0)) begin
              len_q[7:0] <= rx_byte_i;
            end else if (idx_q == field_idx_t'(1)) begin
              len_q[15:8] <= rx_byte_i;
            end
            idx_q <= idx_q + field_idx_t'(1);
            if (idx_q == field_idx_t'(7)) begin
              state_q <= SEND_ACK;
            end
          end
        end
        SEND_ACK: begin
          if (tx_fire) begin
            if (!cmd_q) begin
              state_q <= IDLE;
            end else if (len_q == '0) begin
              state_q <= SEND_EOT;
            end else if (is_read_q) begin
              state_q <= RD_FETCH;
            end else begin
              state_q <= WR_DATA;
            end
          end
        end
        WR_DATA: begin
          if (rx_valid_i) begin
            addr_q <= addr_q + mem_addr_t'(1);
            len_q  <= len_q - xfer_len_t'(1);
            if (last_byte) begin
              state_q <= SEND_EOT;
            end
          end
        end
        RD_FETCH: begin
          state_q <= RD_SEND;
        end
        RD_SEND: begin
          if (tx_fire) begin
            addr_q  <= addr_q + mem_addr_t'(1);
            len_q   <= len_q - xfer_len_t'(1);
            state_q <= last_byte ? SEND_EOT : RD_FETCH;
          end
        end
        SEND_EOT: begin
          if (tx_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte memory
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == WR_DATA && rx_valid_i) begin
      mem_q[addr_q] <= rx_byte_i;
    end
    // Registered read, held through RD_SEND
    if (state_q == RD_FETCH) begin
      rd_data_q <= mem_q[addr_q];
    end
  end

  // Reply byte follows the state directly
  assign tx_valid_o = (state_q == SEND_ACK) || (state_q == RD_SEND) || (state_q == SEND_EOT);

  always_comb begin
    case (state_q)
      SEND_ACK: tx_byte_o = `UART_DBG_ACK;
      SEND_EOT: tx_byte_o = `UART_DBG_EOT;
      default:  tx_byte_o = rd_data_q;
    endcase
  end

endmodule

// ==== hw/uart_dbg_top.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the UART debug server. Connects the serial receiver,
// the command engine and the serial transmitter.
//////////////////////////////////////////////////////////////////////

module uart_dbg_top (
  input  logic clk,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  import uart_dbg_pkg::*;

  // Receiver to engine, strobe only
  logic  rx_valid;
  byte_t rx_byte;

  // Engine to transmitter handshake
  logic  tx_valid;
  byte_t tx_byte;
  logic  tx_ready;

  uart_dbg_rx u_rx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_dbg_engine u_engine (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .rx_valid_i ( rx_valid ),
    .rx_byte_i  ( rx_byte  ),
    .tx_valid_o ( tx_valid ),
    .tx_byte_o  ( tx_byte  ),
    .tx_ready_i ( tx_ready )
  );

  uart_dbg_tx u_tx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_valid_i ( tx_valid  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Clock and reset source of the testbench. 4 ns clock, reset held
// low for the first two clock cycles.
//////////////////////////////////////////////////////////////////////

module tb_clk_gen #(
  parameter int unsigned reset_cycles = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (reset_cycles) @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== dv/uart_dbg_properties.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the serial output, the receiver strobe and the
// engine to transmitter handshake. Bound into the top level.
//////////////////////////////////////////////////////////////////////

module uart_dbg_properties (
  input logic                clk,
  input logic                arst_n_i,
  input logic                uart_tx_i,
  input logic                rx_valid_i,
  input logic                tx_valid_i,
  input uart_dbg_pkg::byte_t tx_byte_i,
  input logic                tx_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // Idle transmitter keeps the line at the stop level
  a_tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_ready_i |-> uart_tx_i)
    else begin
      $error("uart_tx_o is low while the transmitter is idle");
      fail_cnt++;
    end

  // One strobe per received byte
  a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    rx_valid_i |=> !rx_valid_i)
    else begin
      $error("rx_valid stayed high for two cycles");
      fail_cnt++;
    end

  // Offered byte waits unchanged for the transmitter
  a_tx_byte_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_byte_i))
    else begin
      $error("tx_valid or tx_byte changed before the handshake");
      fail_cnt++;
    end

endmodule

bind uart_dbg_top uart_dbg_properties u_props (
  .clk        ( clk       ),
  .arst_n_i   ( arst_n_i  ),
  .uart_tx_i  ( uart_tx_o ),
  .rx_valid_i ( rx_valid  ),
  .tx_valid_i ( tx_valid  ),
  .tx_byte_i  ( tx_byte   ),
  .tx_ready_i ( tx_ready  )
);

// ==== dv/tb_uart_dbg.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench of the UART debug server. Drives host frames into the
// serial input, collects reply frames from the serial output and runs
// directed tests against a byte model of the target memory.
//////////////////////////////////////////////////////////////////////

`include "uart_dbg_defines.svh"

module tb_uart_dbg;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned bit_cyc     = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned mem_depth   = `UART_DBG_MEM_DEPTH;
  // Sent and received frames of all tests, quiet windows included
  localparam int unsigned frame_total = 200;
  localparam int unsigned wd_cycles   = frame_total * 10 * bit_cyc * 3 / 2;

  logic        clk;
  logic        arst_n;
  logic        uart_rx;
  logic        uart_tx;
  logic [31:0] rng_state = 32'h77f3a8cd;
  logic [7:0]  reply_q[$];
  logic [7:0]  mem_model [mem_depth];

  tb_clk_gen u_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  uart_dbg_top dut (
    .clk       ( clk     ),
    .arst_n_i  ( arst_n  ),
    .uart_rx_i ( uart_rx ),
    .uart_tx_o ( uart_tx )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Line level driver and monitor
  ////////////////////////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rx = frame[i];
      repeat (bit_cyc - 1) @(negedge clk);
    end
  endtask

  task automatic recv_byte(output logic [7:0] b);
    @(negedge clk);
    while (uart_tx !== 1'b0) @(negedge clk);
    // Move to the middle of the start bit
    repeat (bit_cyc / 2) @(negedge clk);
    if (uart_tx !== 1'b0) begin
      abort_run("A start bit on uart_tx_o ended before its middle");
    end
    for (int i = 0; i < 8; i++) begin
      repeat (bit_cyc) @(negedge clk);
      b[i] = uart_tx;
    end
    repeat (bit_cyc) @(negedge clk);
    if (uart_tx !== 1'b1) begin
      abort_run("A frame on uart_tx_o had a low stop bit");
    end
  endtask

  task automatic expect_reply(input logic [7:0] exp, input string name);
    int unsigned waited;
    waited = 0;
    while (reply_q.size() == 0) begin
      if (waited == 30 * bit_cyc) begin
        abort_run($sformatf("No reply frame for %s within 30 bit periods", name));
      end
      @(negedge clk);
      waited++;
    end
    check_val(name, reply_q.pop_front(), exp);
  endtask

  // Line stays high and no frame is pending
  task automatic check_quiet(input int unsigned bits);
    repeat (bits * bit_cyc) begin
      @(negedge clk);
      check_val("uart_tx_o", uart_tx, 1'b1);
    end
    check_val("uart_tx_o frame count", reply_q.size(), 0);
    check_val("assertion failures", dut.u_props.fail_cnt, 0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Exchanges and directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic send_header(input logic [7:0] cmd, input logic [63:0] addr,
                             input logic [63:0] len);
    send_byte(cmd);
    for (int i = 0; i < 8; i++) send_byte(addr[8*i +: 8]);
    for (int i = 0; i < 8; i++) send_byte(len[8*i +: 8]);
  endtask

  task automatic mem_write(input logic [63:0] addr, input logic [63:0] len);
    int unsigned count;
    logic [7:0]  b;
    count = len[15:0];
    send_header(`UART_DBG_CMD_WRITE, addr, len);
    expect_reply(`UART_DBG_ACK, "uart_tx_o write ACK");
    for (int unsigned i = 0; i < count; i++) begin
      b = rand_byte();
      mem_model[(addr + i) % mem_depth] = b;
      send_byte(b);
    end
    expect_reply(`UART_DBG_EOT, "uart_tx_o write EOT");
    check_quiet(4);
  endtask

  task automatic mem_read(input logic [63:0] addr, input logic [63:0] len);
    int unsigned count;
    count = len[15:0];
    send_header(`UART_DBG_CMD_READ, addr, len);
    expect_reply(`UART_DBG_ACK, "uart_tx_o read ACK");
    for (int unsigned i = 0; i < count; i++) begin
      expect_reply(mem_model[(addr + i) % mem_depth],
                   $sformatf("uart_tx_o read data %0d", i));
    end
    expect_reply(`UART_DBG_EOT, "uart_tx_o read EOT");
    check_quiet(4);
  endtask

  task automatic reset_idle();
    check_quiet(20);
  endtask

  task automatic ack_challenge();
    send_byte(`UART_DBG_ACK);
    expect_reply(`UART_DBG_ACK, "uart_tx_o ACK reply");
    check_quiet(20);
  endtask

  task automatic write_read_back();
    mem_write(64'h20, 64'd16);
    mem_read(64'h20, 64'd16);
  endtask

  task automatic wrap_around();
    mem_write(64'hfe, 64'd4);
    mem_read(64'h00, 64'd2);
  endtask

  // Nonzero bytes above the used address and length bits
  task automatic high_field_bytes();
    mem_write({48'h5a3c_91e7_d2b4, 16'hff20}, {48'hc3a5_0f96_7e18, 16'd4});
    mem_read(64'h20, 64'd4);
    mem_read({48'h1b7d_e430_96fa, 16'hff20}, {48'h8e21_f06c_d953, 16'd4});
  endtask

  task automatic unknown_byte();
    send_byte(8'h55);
    check_quiet(20);
    ack_challenge();
  endtask

  initial begin : reply_monitor
    logic [7:0] b;
    @(posedge arst_n);
    forever begin
      recv_byte(b);
      reply_q.push_back(b);
    end
  end

  initial begin : watchdog
    repeat (wd_cycles) @(posedge clk);
    abort_run("Watchdog expired before the tests finished");
  end

  initial begin : main
    uart_rx = 1'b1;
    @(posedge arst_n);
    reset_idle();
    ack_challenge();
    write_read_back();
    wrap_around();
    high_field_bytes();
    unknown_byte();
    if (dut.u_props.fail_cnt != 0) begin
      abort_run($sformatf("%0d assertion failures were reported", dut.u_props.fail_cnt));
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/uart_dbg_pkg.sv
hw/uart_dbg_rx.sv
hw/uart_dbg_tx.sv
hw/uart_dbg_engine.sv
hw/uart_dbg_top.sv
dv/tb_clk_gen.sv
dv/uart_dbg_properties.sv
dv/tb_uart_dbg.sv

// ==== Bender.yml ====
package:
  name: uart_dbg

sources:
  - include_dirs:
      - hw
    files:
      - hw/uart_dbg_pkg.sv
      - hw/uart_dbg_rx.sv
      - hw/uart_dbg_tx.sv
      - hw/uart_dbg_engine.sv
      - hw/uart_dbg_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clk_gen.sv
      - dv/uart_dbg_properties.sv
      - dv/tb_uart_dbg.sv
